/* hdl/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int ROB_DEPTH  = 16;             // Entries in the buffer
    localparam int TAG_W      = 4;              // Tag bits, log2 of depth
    localparam int MUL_STAGES = 3;              // Multiplier pipeline depth
    localparam int DIV_STEPS  = 32;             // One quotient bit per step

    typedef logic [31:0]      word_t;           // Data word
    typedef logic [TAG_W-1:0] rob_tag_t;        // Entry index
    typedef logic [TAG_W:0]   rob_cnt_t;        // Occupancy 0..ROB_DEPTH
    typedef logic [4:0]       reg_idx_t;        // Destination register
    typedef logic [1:0]       op_kind_t;        // Operation class
    typedef logic [5:0]       div_cnt_t;        // Divider steps left

    localparam op_kind_t OP_ADD = 2'd0;         // a + b, wraps at 2^32
    localparam op_kind_t OP_MUL = 2'd1;         // Low word of a * b
    localparam op_kind_t OP_DIV = 2'd2;         // Unsigned a / b, ones on b == 0

    typedef struct packed {
        op_kind_t kind;                         // Selects execution path
        reg_idx_t dest;
        logic     reg_write;
        word_t    a;                            // Dividend for divides
        word_t    b;                            // Divisor for divides
    } disp_op_t;

    typedef struct packed {
        disp_op_t op;
        rob_tag_t tag;                          // Entry that receives the result
    } exec_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } exec_res_t;

    typedef struct packed {
        reg_idx_t dest;
        logic     reg_write;
        word_t    value;
    } commit_t;

    typedef enum logic {
        ST_RUN,                                 // Dispatch open
        ST_DRAIN                                // Waiting for paths to go idle
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hdl/rob_ptr_ctr.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctr (
    input  wire                clk,
    input  wire                rst,
    input  wire                alloc,         // New entry at tail
    input  wire                retire,        // Head entry leaves
    input  wire                squash_valid,
    input  wire rob_pkg::rob_tag_t squash_tag, // Oldest entry to keep
    output rob_pkg::rob_tag_t  head,
    output rob_pkg::rob_tag_t  tail,
    output logic               full,
    output logic               empty
);
    import rob_pkg::*;

    rob_cnt_t count;                            // Live entries
    rob_tag_t keep_span;                        // Offset of squash tag from head

    assign keep_span = squash_tag - head;       // Wraps mod ROB_DEPTH
    assign full      = (count == rob_cnt_t'(ROB_DEPTH));
    assign empty     = (count == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head + 1'b1;            // Natural wrap at 16
            end
            if (squash_valid) begin
                // Survivors are head..squash_tag, less the one retiring now
                tail  <= squash_tag + 1'b1;
                count <= rob_cnt_t'(keep_span) + 1'b1 - rob_cnt_t'(retire);
            end else begin
                if (alloc) begin
                    tail <= tail + 1'b1;
                end
                count <= count + rob_cnt_t'(alloc) - rob_cnt_t'(retire); // Both may fire
            end
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (rst) count <= rob_cnt_t'(ROB_DEPTH)
    ) else $error("rob_ptr_ctr: occupancy above depth");

    a_no_alloc_full : assert property (
        @(posedge clk) disable iff (rst) !(alloc && full)
    ) else $error("rob_ptr_ctr: allocation into a full buffer");

endmodule

`default_nettype wire

/* hdl/rob_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl_fsm (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    disp_valid,
    input  wire rob_pkg::disp_op_t disp_op,
    input  wire                    full,       // No free entry
    input  wire                    busy,       // Mul or div in flight
    input  wire                    div_busy,   // Divider occupied
    input  wire                    squash_valid,
    output logic                   disp_ready,
    output logic                   alloc,      // Accepted dispatch
    output logic                   draining
);
    import rob_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        div_block;                    // Second divide must wait

    assign div_block = (disp_op.kind == OP_DIV) && div_busy;

    // Squash cycle also closes dispatch so the tail rewind stays clean
    assign disp_ready = (state == ST_RUN) && !full && !div_block && !squash_valid;
    assign alloc      = disp_valid && disp_ready;
    assign draining   = (state == ST_DRAIN);

    always_comb begin
        state_nxt = state;                     // Hold by default
        case (state)
            ST_RUN: begin
                if (squash_valid) begin
                    state_nxt = ST_DRAIN;      // Redirect seen
                end
            end
            ST_DRAIN: begin
                if (!busy && !squash_valid) begin
                    state_nxt = ST_RUN;        // Stale results all returned
                end
            end
            default: begin
                state_nxt = ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // No tag reuse until the squashed work has left the paths
    a_no_alloc_drain : assert property (
        @(posedge clk) disable iff (rst) (state == ST_DRAIN) |-> !alloc
    ) else $error("rob_ctrl_fsm: dispatch accepted while draining");

endmodule

`default_nettype wire

/* hdl/rob_store.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_store (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     alloc,
    input  wire rob_pkg::rob_tag_t  tail,         // Entry being allocated
    input  wire rob_pkg::rob_tag_t  head,         // Oldest entry
    input  wire rob_pkg::disp_op_t  disp_op,
    input  wire rob_pkg::exec_res_t add_res,
    input  wire rob_pkg::exec_res_t mul_res,
    input  wire rob_pkg::exec_res_t div_res,
    input  wire                     squash_valid,
    input  wire rob_pkg::rob_tag_t  squash_tag,
    output logic                    retire,       // Head leaves this edge
    output logic                    commit_valid,
    output rob_pkg::commit_t        commit
);
    import rob_pkg::*;

    logic [ROB_DEPTH-1:0] ent_valid;              // Allocated and not squashed
    logic [ROB_DEPTH-1:0] ent_ready;              // Result has arrived
    reg_idx_t             ent_dest  [ROB_DEPTH];
    logic                 ent_rw    [ROB_DEPTH];
    word_t                ent_value [ROB_DEPTH];
    exec_res_t            res_bus   [3];          // All writeback ports
    rob_tag_t             kill_base;              // First discarded tag
    rob_tag_t             kill_span;              // Number discarded
    logic [ROB_DEPTH-1:0] kill_mask;
    logic                 wb_clash;

    assign res_bus[0] = add_res;
    assign res_bus[1] = mul_res;
    assign res_bus[2] = div_res;

    assign kill_base = squash_tag + 1'b1;
    assign kill_span = tail - kill_base;          // Up to the old tail

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            kill_mask[i] = squash_valid && (rob_tag_t'(i - kill_base) < kill_span);
        end
    end

    assign retire = ent_valid[head] && ent_ready[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid    <= '0;
            ent_ready    <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;               // One cycle after ready
            for (int r = 0; r < 3; r++) begin
                if (res_bus[r].valid && ent_valid[res_bus[r].tag]) begin
                    ent_ready[res_bus[r].tag] <= 1'b1; // Stale tags dropped
                end
            end
            for (int i = 0; i < ROB_DEPTH; i++) begin
                if (kill_mask[i]) begin
                    ent_valid[i] <= 1'b0;
                end
            end
            if (retire) begin
                ent_valid[head] <= 1'b0;
            end
            if (alloc) begin
                ent_valid[tail] <= 1'b1;
                ent_ready[tail] <= 1'b0;          // Wipes leftover ready of a squash
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < 3; r++) begin
            if (res_bus[r].valid && ent_valid[res_bus[r].tag]) begin
                ent_value[res_bus[r].tag] <= res_bus[r].value;
            end
        end
        if (alloc) begin
            ent_dest[tail] <= disp_op.dest;
            ent_rw[tail]   <= disp_op.reg_write;
        end
        if (retire) begin
            commit <= '{dest: ent_dest[head], reg_write: ent_rw[head],
                        value: ent_value[head]};
        end
    end

    always_comb begin
        wb_clash = 1'b0;
        for (int r = 0; r < 3; r++) begin
            wb_clash = wb_clash || (res_bus[r].valid && ent_valid[res_bus[r].tag]
                                    && ent_ready[res_bus[r].tag]);
        end
    end

    // Each live tag gets exactly one result from the execution paths
    a_single_wb : assert property (
        @(posedge clk) disable iff (rst) !wb_clash
    ) else $error("rob_store: second result for a ready entry");

endmodule

`default_nettype wire

/* hdl/exec_units.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_units (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     alloc,
    input  wire rob_pkg::exec_req_t req,
    output rob_pkg::exec_res_t      add_res,
    output rob_pkg::exec_res_t      mul_res,
    output rob_pkg::exec_res_t      div_res,
    output logic                    busy,
    output logic                    div_busy
);
    import rob_pkg::*;

    logic                  add_go;
    logic                  mul_go;
    logic                  div_go;
    logic                  add_v;
    rob_tag_t              add_tag;
    word_t                 add_val;
    logic [MUL_STAGES-1:0] mul_v;                    // Valid per stage
    rob_tag_t              mul_tag [MUL_STAGES];
    word_t                 mul_val [MUL_STAGES];
    logic                  div_v;
    rob_tag_t              div_tag;
    word_t                 div_quo;                  // Dividend shifts out, quotient in
    word_t                 div_rem;
    word_t                 div_dvs;
    div_cnt_t              div_cnt;                  // Steps left
    logic [32:0]           rem_sh;
    logic [33:0]           rem_diff;                 // Bit 33 set means negative

    always_comb begin
        add_go = 1'b0;
        mul_go = 1'b0;
        div_go = 1'b0;
        case (req.op.kind)
            OP_MUL:  mul_go = alloc;
            OP_DIV:  div_go = alloc;
            OP_ADD:  add_go = alloc;
            default: add_go = alloc;                 // Spare code runs as an add
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            add_v <= 1'b0;
            mul_v <= '0;
        end else begin
            add_v <= add_go;
            mul_v <= {mul_v[MUL_STAGES-2:0], mul_go};
        end
    end

    always_ff @(posedge clk) begin
        if (add_go) begin
            add_tag <= req.tag;
            add_val <= req.op.a + req.op.b;          // Carry out dropped
        end
        mul_tag[0] <= req.tag;
        mul_val[0] <= req.op.a * req.op.b;           // Low 32 bits kept
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_tag[s] <= mul_tag[s-1];
            mul_val[s] <= mul_val[s-1];
        end
    end

    // Restoring step, a zero divisor never goes negative so all ones fall out
    assign rem_sh   = {div_rem, div_quo[31]};
    assign rem_diff = {1'b0, rem_sh} - {2'b00, div_dvs};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_busy <= 1'b0;
            div_v    <= 1'b0;
            div_cnt  <= '0;
        end else begin
            div_v <= 1'b0;
            if (div_go) begin
                div_busy <= 1'b1;                    // Load cycle
                div_cnt  <= div_cnt_t'(DIV_STEPS);
            end else if (div_busy) begin
                div_cnt <= div_cnt - 1'b1;
                if (div_cnt == div_cnt_t'(1)) begin
                    div_busy <= 1'b0;                // Last bit lands now
                    div_v    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_go) begin
            div_tag <= req.tag;
            div_quo <= req.op.a;
            div_dvs <= req.op.b;
            div_rem <= '0;
        end else if (div_busy) begin
            div_quo <= {div_quo[30:0], ~rem_diff[33]};
            div_rem <= rem_diff[33] ? rem_sh[31:0] : rem_diff[31:0]; // Restore on borrow
        end
    end

    assign add_res = '{valid: add_v, tag: add_tag, value: add_val};
    assign mul_res = '{valid: mul_v[MUL_STAGES-1], tag: mul_tag[MUL_STAGES-1],
                       value: mul_val[MUL_STAGES-1]};
    assign div_res = '{valid: div_v, tag: div_tag, value: div_quo};

    assign busy = (|mul_v) || div_busy;              // Adder never outlives a cycle

endmodule

`default_nettype wire

/* hdl/rob_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_core_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    disp_valid,
    input  wire rob_pkg::disp_op_t disp_op,
    input  wire                    squash_valid,
    input  wire rob_pkg::rob_tag_t squash_tag,   // Oldest entry to keep
    output logic                   disp_ready,
    output rob_pkg::rob_tag_t      disp_tag,     // Tag of next dispatch
    output logic                   commit_valid,
    output rob_pkg::commit_t       commit
);
    import rob_pkg::*;

    logic      alloc;
    logic      retire;
    logic      full;
    logic      empty;
    logic      busy;
    logic      div_busy;
    logic      draining;
    rob_tag_t  head;
    rob_tag_t  tail;
    exec_req_t exec_req;
    exec_res_t add_res;
    exec_res_t mul_res;
    exec_res_t div_res;

    assign exec_req = '{op: disp_op, tag: tail};
    assign disp_tag = tail;

    rob_ctrl_fsm u_ctrl (
        .clk(clk), .rst(rst), .disp_valid(disp_valid), .disp_op(disp_op),
        .full(full), .busy(busy), .div_busy(div_busy), .squash_valid(squash_valid),
        .disp_ready(disp_ready), .alloc(alloc), .draining(draining)
    );

    rob_ptr_ctr u_ptr (
        .clk(clk), .rst(rst), .alloc(alloc), .retire(retire),
        .squash_valid(squash_valid), .squash_tag(squash_tag),
        .head(head), .tail(tail), .full(full), .empty(empty)
    );

    rob_store u_store (
        .clk(clk), .rst(rst), .alloc(alloc), .tail(tail), .head(head),
        .disp_op(disp_op), .add_res(add_res), .mul_res(mul_res), .div_res(div_res),
        .squash_valid(squash_valid), .squash_tag(squash_tag),
        .retire(retire), .commit_valid(commit_valid), .commit(commit)
    );

    exec_units u_exec (
        .clk(clk), .rst(rst), .alloc(alloc), .req(exec_req),
        .add_res(add_res), .mul_res(mul_res), .div_res(div_res),
        .busy(busy), .div_busy(div_busy)
    );

    // Counter and store agree on occupancy
    a_no_retire_empty : assert property (
        @(posedge clk) disable iff (rst) empty |-> !retire
    ) else $error("rob_core_top: retire from an empty buffer");

    // Tail frozen through a drain
    a_drain_tail : assert property (
        @(posedge clk) disable iff (rst) (draining && !squash_valid) |=> $stable(tail)
    ) else $error("rob_core_top: tail moved while draining");

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #4 clk = ~clk;                            // 8 ns period
endmodule

`default_nettype wire

/* verif/tb_rob_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob_core;
    import rob_pkg::*;

    typedef struct packed {
        rob_tag_t tag;                               // Entry the op was given
        commit_t  rec;                               // Record it must retire with
    } exp_ent_t;

    logic        clk;
    logic        rst;
    logic        disp_valid;
    disp_op_t    disp_op;
    logic        squash_valid;
    rob_tag_t    squash_tag;
    logic        disp_ready;
    rob_tag_t    disp_tag;
    logic        commit_valid;
    commit_t     commit;
    exp_ent_t    exp_q [$];                          // Model, oldest first
    commit_t     exp_head;
    int          exp_cnt;
    rob_tag_t    exp_tag;                            // Tag the next accept gets
    logic        reset_quiet;                        // Nothing dispatched yet
    logic        expect_closed;                      // Dispatch must be refused
    logic [31:0] lcg_state = 32'h2604;
    int          cycle;
    int          mismatches;
    int          timeouts;
    rob_tag_t    last_tag;
    int          last_cycle;                         // Edge count after last accept
    rob_tag_t    keep_tag;
    int          div_cycle;

    tb_clk_gen u_clk (.clk(clk));

    rob_core_top UUT (
        .clk(clk), .rst(rst), .disp_valid(disp_valid), .disp_op(disp_op),
        .squash_valid(squash_valid), .squash_tag(squash_tag), .disp_ready(disp_ready),
        .disp_tag(disp_tag), .commit_valid(commit_valid), .commit(commit)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t op_result(input disp_op_t op);
        case (op.kind)
            OP_MUL:  return op.a * op.b;             // Low word of the product
            OP_DIV:  return (op.b == '0) ? '1 : op.a / op.b;
            default: return op.a + op.b;             // Wraps at 2^32
        endcase
    endfunction

    function automatic disp_op_t make_op(input op_kind_t kind, input reg_idx_t dest,
                                         input word_t a, input word_t b);
        disp_op_t op;
        op.kind      = kind;
        op.dest      = dest;
        op.reg_write = (dest != 5'd0);               // r0 never written
        op.a         = a;
        op.b         = b;
        return op;
    endfunction

    function automatic disp_op_t random_op();
        logic [31:0] pick;
        disp_op_t    op;
        pick         = next_rand();
        op.kind      = (pick[31:30] == 2'd3) ? OP_DIV : (pick[29] ? OP_MUL : OP_ADD);
        op.dest      = pick[27:23];
        op.reg_write = pick[22];
        op.a         = next_rand();
        op.b         = next_rand();
        if (op.kind == OP_DIV && pick[21:20] == 2'd0) begin
            op.b = '0;                               // Zero divisor now and then
        end else if (op.kind == OP_DIV && pick[19]) begin
            op.b = {24'h0, op.b[31:24]};             // Small divisor, wide quotient
        end
        return op;
    endfunction

    function automatic void refresh_head();
        exp_cnt = exp_q.size();
        if (exp_q.size() > 0) begin
            exp_head = exp_q[0].rec;
        end else begin
            exp_head = '0;
        end
    endfunction

    task automatic note_mismatch(input string msg);
        mismatches++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    // Every retirement must match the oldest live op of the model
    commit_check : assert property (@(negedge clk) disable iff (rst)
        commit_valid |-> (exp_cnt > 0 && commit == exp_head)
    ) else note_mismatch($sformatf("commit r%0d/%0b=%h, expected r%0d/%0b=%h, %0d pending",
        commit.dest, commit.reg_write, commit.value,
        exp_head.dest, exp_head.reg_write, exp_head.value, exp_cnt));

    quiet_check : assert property (@(negedge clk) disable iff (rst)
        reset_quiet |-> (!commit_valid && disp_ready)
    ) else note_mismatch("commit or closed dispatch before the first op");

    // A commit frees an entry, so that cycle is exempt
    closed_check : assert property (@(negedge clk) disable iff (rst)
        (expect_closed && !commit_valid) |-> !disp_ready
    ) else note_mismatch("disp_ready high while dispatch should be blocked");

    // Next tag steps on each accept and rewinds on a squash
    tag_check : assert property (@(negedge clk) disable iff (rst)
        disp_tag == exp_tag
    ) else note_mismatch($sformatf("disp_tag %0d, expected %0d", disp_tag, exp_tag));

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && commit_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());                // Retired, drop from model
            refresh_head();
        end
    end

    task automatic idle_cycles(input int n);
        disp_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    // Valid only rises once ready is seen with the op on the bus
    task automatic dispatch(input disp_op_t op);
        int       guard;
        exp_ent_t ent;
        guard = 0;
        disp_op     <= op;
        disp_valid  <= 1'b0;
        reset_quiet <= 1'b0;
        @(negedge clk);
        while (!disp_ready && guard < 100) begin
            @(negedge clk);
            guard++;
        end
        if (!disp_ready) begin
            timeouts++;
            $display("Timeout at %0t: dispatch was never ready", $time);
            @(posedge clk);
        end else begin
            @(posedge clk);
            disp_valid <= 1'b1;
            @(negedge clk);
            ent.tag = exp_tag;
            ent.rec = '{dest: op.dest, reg_write: op.reg_write, value: op_result(op)};
            exp_q.push_back(ent);
            refresh_head();
            last_tag   = exp_tag;
            last_cycle = cycle + 1;
            @(posedge clk);                          // Accepting edge
            disp_valid <= 1'b0;
            exp_tag = exp_tag + 1'b1;
        end
    endtask

    task automatic wait_commit();
        int guard;
        guard = 0;
        @(negedge clk);
        while (!commit_valid && guard < 100) begin
            @(negedge clk);
            guard++;
        end
        if (!commit_valid) begin
            timeouts++;
            $display("Timeout at %0t: no commit arrived", $time);
        end
    endtask

    task automatic wait_drained();
        int guard;
        guard = 0;
        @(negedge clk);
        while (exp_cnt > 0 && guard < 200) begin
            @(negedge clk);
            guard++;
        end
        if (exp_cnt > 0) begin
            timeouts++;
            $display("Timeout at %0t: %0d ops never committed", $time, exp_cnt);
        end
        @(posedge clk);
    endtask

    task automatic squash_at(input rob_tag_t keep);
        squash_valid <= 1'b1;
        squash_tag   <= keep;
        while (exp_q.size() > 0 && exp_q[$].tag != keep) begin
            void'(exp_q.pop_back());                 // Younger ops never retire
        end
        refresh_head();
        @(posedge clk);
        squash_valid  <= 1'b0;
        expect_closed <= 1'b1;                       // Drain under way
        exp_tag = keep + 1'b1;
    endtask

    initial begin
        rst           = 1'b1;
        disp_valid    = 1'b0;
        disp_op       = '0;
        squash_valid  = 1'b0;
        squash_tag    = '0;
        reset_quiet   = 1'b0;
        expect_closed = 1'b0;
        exp_tag       = '0;
        refresh_head();
        repeat (8) @(posedge clk);
        rst         <= 1'b0;
        reset_quiet <= 1'b1;
        idle_cycles(5);

        // Divide at head holds back the quick adds behind it
        dispatch(make_op(OP_DIV, 5'd1, 32'd100000, 32'd7));
        for (int i = 0; i < 4; i++) begin
            dispatch(make_op(OP_ADD, reg_idx_t'(i + 2), 32'hFFFF_FFF0, word_t'(i * 9)));
        end
        dispatch(make_op(OP_MUL, 5'd6, 32'h0001_0003, 32'hFFFF_0001));
        dispatch(make_op(OP_DIV, 5'd7, 32'hDEAD_BEEF, 32'd0));
        wait_drained();

        for (int i = 0; i < 40; i++) begin
            dispatch(random_op());
            idle_cycles(int'(next_rand() >> 30));    // Gap of 0 to 3 cycles
        end
        wait_drained();

        // Sixteen outstanding behind a slow head
        dispatch(make_op(OP_DIV, 5'd2, 32'hFFFF_FFFF, 32'd3));
        for (int i = 0; i < ROB_DEPTH - 1; i++) begin
            dispatch(make_op(OP_ADD, reg_idx_t'(i + 8), word_t'(i), 32'd5));
        end
        expect_closed <= 1'b1;
        disp_op       <= make_op(OP_ADD, 5'd9, 32'd1, 32'd2);
        wait_commit();
        assert (disp_ready) else note_mismatch("disp_ready still low after a commit");
        @(posedge clk);
        expect_closed <= 1'b0;
        wait_drained();

        // Second divide must wait for the divider
        dispatch(make_op(OP_DIV, 5'd3, 32'd77777, 32'd9));
        expect_closed <= 1'b1;
        disp_op       <= make_op(OP_DIV, 5'd4, 32'd5, 32'd0);
        idle_cycles(10);
        expect_closed <= 1'b0;
        dispatch(make_op(OP_DIV, 5'd4, 32'd5, 32'd0));
        wait_drained();

        // Redirect keeps the divide, drops the three behind it
        dispatch(make_op(OP_ADD, 5'd10, 32'd40, 32'd2));
        dispatch(make_op(OP_DIV, 5'd11, 32'd1000000, 32'd13));
        keep_tag  = last_tag;
        div_cycle = last_cycle;
        dispatch(make_op(OP_ADD, 5'd12, 32'd1, 32'd1));
        dispatch(make_op(OP_ADD, 5'd13, 32'd2, 32'd2));
        dispatch(make_op(OP_MUL, 5'd14, 32'd300, 32'd7));    // Still in the multiplier
        squash_at(keep_tag);
        repeat (div_cycle + 28 - cycle) @(posedge clk);      // Divider still busy here
        expect_closed <= 1'b0;
        wait_drained();
        dispatch(make_op(OP_MUL, 5'd15, 32'h1234_5678, 32'd16));
        dispatch(make_op(OP_ADD, 5'd16, 32'h8000_0000, 32'h8000_0001));
        dispatch(make_op(OP_DIV, 5'd17, 32'd999, 32'd10));
        wait_drained();
        idle_cycles(4);

        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
hdl/rob_pkg.sv
hdl/rob_ptr_ctr.sv
hdl/rob_ctrl_fsm.sv
hdl/rob_store.sv
hdl/exec_units.sv
hdl/rob_core_top.sv
verif/tb_clk_gen.sv
verif/tb_rob_core.sv

/* Makefile */
TOP := tb_rob_core

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
